/* logic/l2w_cfg_pkg.sv */
`default_nettype none

package l2w_cfg_pkg;

    // field widths of the write path.
    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;
    localparam int STRB_W = WORD_W / 8;
    localparam int LEN_W  = 8;

    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_W         = WORDS_PER_LINE * WORD_W;

    typedef logic [ADDR_W-1:0] addr_t;  // byte address.
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [STRB_W-1:0] strb_t;  // one bit per byte lane.
    typedef logic [LEN_W-1:0]  len_t;   // beats minus one.
    typedef logic [LINE_W-1:0] line_t;  // word 0 sits in the low bits.

    // burst length codes.
    localparam len_t LINE_LEN   = len_t'(WORDS_PER_LINE - 1);
    localparam len_t SINGLE_LEN = len_t'(0);

    localparam strb_t FULL_STRB = '1;

endpackage

`default_nettype wire

/* logic/l2w_bus_pkg.sv */
`default_nettype none

package l2w_bus_pkg;
    import l2w_cfg_pkg::*;

    // write request as handed over by the cache.
    typedef struct packed {
        addr_t addr;
        line_t line;      // full line, or the word in bits 31:0.
        strb_t strb;      // only meaningful when uncached.
        logic  uncached;
    } l2w_req_t;

    // line hand-off from the arbiter into the buffer.
    typedef struct packed {
        addr_t base;
        line_t data;
    } line_wr_t;

    // one beat on the memory bus, address and data together.
    typedef struct packed {
        addr_t addr;
        len_t  len;
        strb_t strb;
        word_t data;
        logic  last;
    } mem_beat_t;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_LINE,     // line waiting for the buffer to free up.
        ARB_UC_SEND,
        ARB_UC_RESP
    } arb_state_t;

endpackage

`default_nettype wire

/* logic/wr_req_intake.sv */
`default_nettype none

module wr_req_intake
    import l2w_bus_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rstn,
    input  wire l2w_req_t req,
    input  wire logic     req_valid,
    output logic          req_ok,
    output l2w_req_t      held_req,
    output logic          held_valid,
    input  wire logic     held_ok
);

    logic     full;
    l2w_req_t req_q;
    logic     take;

    // req_valid is still up while req_ok is high, so skip that cycle.
    assign take = req_valid && !full && !req_ok;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            full   <= 1'b0;
            req_ok <= 1'b0;
        end else begin
            req_ok <= held_ok && full;  // one ack per retired request.
            if (held_ok && full) begin
                full <= 1'b0;
            end else if (take) begin
                full <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            req_q <= req;
        end
    end

    assign held_req   = req_q;
    assign held_valid = full;

endmodule

`default_nettype wire

/* logic/write_arbiter.sv */
`default_nettype none

module write_arbiter
    import l2w_cfg_pkg::*, l2w_bus_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rstn,
    input  wire l2w_req_t  held_req,
    input  wire logic      held_valid,
    output logic           held_ok,
    output line_wr_t       line_wr,
    output logic           line_valid,
    input  wire logic      line_ok,
    input  wire logic      line_busy,
    output logic           dma_lock,
    input  wire mem_beat_t buf_beat,
    input  wire logic      buf_valid,
    output logic           buf_ready,
    input  wire logic      buf_bready,
    output logic           buf_bvalid,
    output mem_beat_t      port_beat,
    output logic           port_valid,
    input  wire logic      port_ready,
    input  wire logic      port_bvalid,
    output logic           port_bready
);

    arb_state_t state, state_nxt;
    mem_beat_t  dir_beat;
    logic       dir_valid;
    logic       dir_ready;
    logic       dir_bready;
    logic       is_line;

    assign is_line = held_valid && !held_req.uncached;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= ARB_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt  = state;
        held_ok    = 1'b0;
        line_valid = 1'b0;
        dir_valid  = 1'b0;
        dir_bready = 1'b0;
        case (state)
            ARB_IDLE: begin
                if (is_line) begin
                    line_valid = 1'b1;  // hand over right away if the buffer is free.
                    held_ok    = line_ok;
                    if (!line_ok) begin
                        state_nxt = ARB_LINE;
                    end
                end else if (held_valid && !line_busy) begin
                    state_nxt = ARB_UC_SEND;  // buffer drained, order is kept.
                end
            end
            ARB_LINE: begin
                line_valid = 1'b1;
                held_ok    = line_ok;
                if (line_ok) begin
                    state_nxt = ARB_IDLE;
                end
            end
            ARB_UC_SEND: begin
                dir_valid = 1'b1;
                if (dir_ready) begin
                    state_nxt = ARB_UC_RESP;
                end
            end
            ARB_UC_RESP: begin
                dir_bready = 1'b1;
                held_ok    = port_bvalid;
                if (port_bvalid) begin
                    state_nxt = ARB_IDLE;
                end
            end
            default: state_nxt = ARB_IDLE;
        endcase
    end

    assign line_wr.base = held_req.addr;
    assign line_wr.data = held_req.line;

    assign dir_beat.addr = held_req.addr;
    assign dir_beat.len  = SINGLE_LEN;
    assign dir_beat.strb = held_req.strb;
    assign dir_beat.data = word_t'(held_req.line);  // low word of the line field.
    assign dir_beat.last = 1'b1;

    assign dma_lock = (state == ARB_UC_SEND) || (state == ARB_UC_RESP);

    // the locked side owns the beat and response channels.
    always_comb begin
        if (dma_lock) begin
            port_beat   = dir_beat;
            port_valid  = dir_valid;
            port_bready = dir_bready;
            dir_ready   = port_ready;
            buf_ready   = 1'b0;
            buf_bvalid  = 1'b0;
        end else begin
            port_beat   = buf_beat;
            port_valid  = buf_valid;
            port_bready = buf_bready;
            dir_ready   = 1'b0;
            buf_ready   = port_ready;
            buf_bvalid  = port_bvalid;
        end
    end

endmodule

`default_nettype wire

/* logic/line_write_buffer.sv */
`default_nettype none

module line_write_buffer
    import l2w_cfg_pkg::*, l2w_bus_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rstn,
    input  wire line_wr_t line_wr,
    input  wire logic     line_valid,
    output logic          line_ok,
    output logic          line_busy,
    input  wire logic     dma_lock,
    output mem_beat_t     buf_beat,
    output logic          buf_valid,
    input  wire logic     buf_ready,
    input  wire logic     buf_bvalid,
    output logic          buf_bready
);

    line_wr_t   line_q;
    logic       busy;
    logic       wait_resp;
    logic [1:0] beat_cnt;
    logic       last_beat;
    logic       capture;
    logic       beat_done;

    assign line_ok   = !busy;
    assign line_busy = busy;
    assign capture   = line_valid && line_ok;
    assign last_beat = beat_cnt == 2'(WORDS_PER_LINE - 1);

    // a lock only holds off the first beat, never the middle of a burst.
    assign buf_valid  = busy && !wait_resp && (beat_cnt != 2'd0 || !dma_lock);
    assign beat_done  = buf_valid && buf_ready;
    assign buf_bready = wait_resp;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy      <= 1'b0;
            wait_resp <= 1'b0;
            beat_cnt  <= 2'd0;
        end else begin
            if (capture) begin
                busy     <= 1'b1;
                beat_cnt <= 2'd0;
            end
            if (beat_done) begin
                beat_cnt <= beat_cnt + 2'd1;  // wraps to 0 after the last beat.
                if (last_beat) begin
                    wait_resp <= 1'b1;
                end
            end
            if (wait_resp && buf_bvalid) begin
                wait_resp <= 1'b0;
                busy      <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            line_q <= line_wr;
        end
    end

    assign buf_beat.addr = line_q.base + addr_t'({beat_cnt, 2'b00});
    assign buf_beat.len  = LINE_LEN;
    assign buf_beat.strb = FULL_STRB;
    assign buf_beat.data = line_q.data[{beat_cnt, 5'd0} +: 32];
    assign buf_beat.last = last_beat;

endmodule

`default_nettype wire

/* logic/axi_wr_port.sv */
`default_nettype none

module axi_wr_port
    import l2w_bus_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rstn,
    input  wire mem_beat_t port_beat,
    input  wire logic      port_valid,
    output logic           port_ready,
    output logic           port_bvalid,
    input  wire logic      port_bready,
    output mem_beat_t      mem_beat,
    output logic           mem_valid,
    input  wire logic      mem_ready,
    input  wire logic      mem_bvalid,
    output logic           mem_bready
);

    mem_beat_t beat_q;
    logic      valid_q;
    logic      load;

    // free when empty or when the held beat leaves this cycle.
    assign port_ready = !valid_q || mem_ready;
    assign load       = port_valid && port_ready;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q <= 1'b0;
        end else if (load) begin
            valid_q <= 1'b1;
        end else if (mem_ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            beat_q <= port_beat;
        end
    end

    assign mem_beat  = beat_q;
    assign mem_valid = valid_q;

    // response goes straight to whoever owns the port.
    assign port_bvalid = mem_bvalid;
    assign mem_bready  = port_bready;

endmodule

`default_nettype wire

/* logic/l2_write_path.sv */
`default_nettype none

module l2_write_path
    import l2w_bus_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rstn,
    input  wire l2w_req_t req,
    input  wire logic     req_valid,
    output logic          req_ok,
    output mem_beat_t     mem_beat,
    output logic          mem_valid,
    input  wire logic     mem_ready,
    input  wire logic     mem_bvalid,
    output logic          mem_bready
);

    l2w_req_t  held_req;
    logic      held_valid;
    logic      held_ok;
    line_wr_t  line_wr;
    logic      line_valid;
    logic      line_ok;
    logic      line_busy;
    logic      dma_lock;
    mem_beat_t buf_beat;
    logic      buf_valid;
    logic      buf_ready;
    logic      buf_bvalid;
    logic      buf_bready;
    mem_beat_t port_beat;
    logic      port_valid;
    logic      port_ready;
    logic      port_bvalid;
    logic      port_bready;

    wr_req_intake u_intake (
        .clk        (clk),
        .rstn       (rstn),
        .req        (req),
        .req_valid  (req_valid),
        .req_ok     (req_ok),
        .held_req   (held_req),
        .held_valid (held_valid),
        .held_ok    (held_ok)
    );

    write_arbiter u_arbiter (
        .clk         (clk),
        .rstn        (rstn),
        .held_req    (held_req),
        .held_valid  (held_valid),
        .held_ok     (held_ok),
        .line_wr     (line_wr),
        .line_valid  (line_valid),
        .line_ok     (line_ok),
        .line_busy   (line_busy),
        .dma_lock    (dma_lock),
        .buf_beat    (buf_beat),
        .buf_valid   (buf_valid),
        .buf_ready   (buf_ready),
        .buf_bready  (buf_bready),
        .buf_bvalid  (buf_bvalid),
        .port_beat   (port_beat),
        .port_valid  (port_valid),
        .port_ready  (port_ready),
        .port_bvalid (port_bvalid),
        .port_bready (port_bready)
    );

    line_write_buffer u_buffer (
        .clk        (clk),
        .rstn       (rstn),
        .line_wr    (line_wr),
        .line_valid (line_valid),
        .line_ok    (line_ok),
        .line_busy  (line_busy),
        .dma_lock   (dma_lock),
        .buf_beat   (buf_beat),
        .buf_valid  (buf_valid),
        .buf_ready  (buf_ready),
        .buf_bvalid (buf_bvalid),
        .buf_bready (buf_bready)
    );

    axi_wr_port u_port (
        .clk         (clk),
        .rstn        (rstn),
        .port_beat   (port_beat),
        .port_valid  (port_valid),
        .port_ready  (port_ready),
        .port_bvalid (port_bvalid),
        .port_bready (port_bready),
        .mem_beat    (mem_beat),
        .mem_valid   (mem_valid),
        .mem_ready   (mem_ready),
        .mem_bvalid  (mem_bvalid),
        .mem_bready  (mem_bready)
    );

endmodule

`default_nettype wire

/* verif/tb_l2_write_path.sv */
`default_nettype none

module tb_l2_write_path
    import l2w_cfg_pkg::*, l2w_bus_pkg::*;
();

    localparam int NUM_ENTRIES  = 8;
    localparam int RESET_CYCLES = 3;
    localparam int IDLE_CYCLES  = 4;
    localparam int DRAIN_CYCLES = 10;
    localparam int TIMEOUT_CYCLES = 200 * NUM_ENTRIES + RESET_CYCLES + IDLE_CYCLES
                                    + DRAIN_CYCLES;
    localparam logic [31:0] SEED = 32'h258c478f;
    localparam logic LINE_WR = 1'b0;
    localparam logic UC_WR   = 1'b1;

    logic      clk;
    logic      rstn;
    l2w_req_t  req;
    logic      req_valid;
    logic      req_ok;
    mem_beat_t mem_beat;
    logic      mem_valid;
    logic      mem_ready;
    logic      mem_bvalid;
    logic      mem_bready;

    l2w_req_t  stim_table [NUM_ENTRIES];
    mem_beat_t exp_q [$];
    mem_beat_t stall_beat;
    logic      stall_prev   = 1'b0;
    int        resp_pending = 0;  // last beats still owed a response.
    int        resp_count   = 0;
    int        ack_count    = 0;
    int        cycle_cnt    = 0;

    l2_write_path u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("error at %0t: %s is %0h, expected %0h",
                               $time, name, got, exp));
        end
    endtask

    function automatic l2w_req_t make_req(input logic uc, input addr_t addr,
                                          input line_t data, input strb_t strb);
        l2w_req_t r;
        r.addr     = addr;
        r.line     = data;
        r.strb     = strb;
        r.uncached = uc;
        return r;
    endfunction

    task automatic load_table();
        stim_table[0] = make_req(LINE_WR, 32'h0000_1000,
                                 128'h10000003_10000002_10000001_10000000, 4'hf);
        stim_table[1] = make_req(UC_WR, 32'h0000_2004,
                                 128'hdeadbeef_deadbeef_deadbeef_cafe0001, 4'b0011);
        stim_table[2] = make_req(LINE_WR, 32'h0000_1040,
                                 128'h20000003_20000002_20000001_20000000, 4'hf);
        stim_table[3] = make_req(LINE_WR, 32'h0000_8000,
                                 128'ha5a50003_a5a50002_a5a50001_a5a50000, 4'hf);
        stim_table[4] = make_req(UC_WR, 32'h0000_300c,
                                 128'h00000000_00000000_00000000_12345678, 4'b1000);
        stim_table[5] = make_req(UC_WR, 32'h0000_3010,
                                 128'h55555555_44444444_33333333_87654321, 4'b0110);
        stim_table[6] = make_req(LINE_WR, 32'h0001_0020,
                                 128'hf00d0003_f00d0002_f00d0001_f00d0000, 4'hf);
        stim_table[7] = make_req(UC_WR, 32'h0001_0030,
                                 128'h00000000_00000000_00000000_0badf00d, 4'hf);
    endtask

    // line: four beats at base+4k, len 3, full strobe, word k; uncached: one beat.
    task automatic push_expected(input l2w_req_t r);
        mem_beat_t b;
        if (r.uncached) begin
            b.addr = r.addr;
            b.len  = 8'd0;
            b.strb = r.strb;
            b.data = r.line[31:0];
            b.last = 1'b1;
            exp_q.push_back(b);
        end else begin
            for (int k = 0; k < 4; k++) begin
                b.addr = r.addr + 32'(4 * k);
                b.len  = 8'd3;
                b.strb = 4'b1111;
                b.data = r.line[32*k +: 32];
                b.last = (k == 3);
                exp_q.push_back(b);
            end
        end
    endtask

    task automatic check_beat(input mem_beat_t got);
        mem_beat_t exp;
        if (exp_q.size() == 0) begin
            fail_run($sformatf("unexpected extra beat on the memory bus at %0t", $time));
        end else begin
            exp = exp_q.pop_front();
            check_value("mem_beat.addr", 128'(got.addr), 128'(exp.addr));
            check_value("mem_beat.len", 128'(got.len), 128'(exp.len));
            check_value("mem_beat.strb", 128'(got.strb), 128'(exp.strb));
            check_value("mem_beat.data", 128'(got.data), 128'(exp.data));
            check_value("mem_beat.last", 128'(got.last), 128'(exp.last));
        end
    endtask

    task automatic send_request(input l2w_req_t r);
        @(posedge clk);
        req       <= r;
        req_valid <= 1'b1;
        @(negedge clk);
        while (!req_ok) begin
            @(negedge clk);
        end
        @(posedge clk);
        req_valid <= 1'b0;
    endtask

    // memory slave, random stalls on both channels.
    always @(posedge clk) begin
        if (rstn) begin
            mem_ready  <= ($urandom % 4) != 0;
            mem_bvalid <= (($urandom % 2) == 1) && (resp_pending > 0);
        end
    end

    // monitor sits mid-cycle, where all DUT outputs have settled.
    always @(negedge clk) begin
        if (ack_count == 0 && !req_valid) begin
            check_value("mem_valid", 128'(mem_valid), 128'(1'b0));
            check_value("mem_bready", 128'(mem_bready), 128'(1'b0));
            check_value("req_ok", 128'(req_ok), 128'(1'b0));
        end
        if (stall_prev) begin
            check_value("mem_valid", 128'(mem_valid), 128'(1'b1));  // held under stall.
            check_value("mem_beat", 128'(mem_beat), 128'(stall_beat));
        end
        stall_prev = mem_valid && !mem_ready;
        stall_beat = mem_beat;
        if (mem_valid && mem_ready) begin
            check_beat(mem_beat);
            if (mem_beat.last) begin
                resp_pending++;
            end
        end
        if (mem_bvalid && mem_bready) begin
            resp_pending--;
            resp_count++;
        end
        if (req_ok) begin
            ack_count++;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            fail_run($sformatf("timeout after %0d cycles with %0d of %0d requests done",
                               cycle_cnt, ack_count, NUM_ENTRIES));
        end
    end

    initial begin
        void'($urandom(SEED));
        rstn       = 1'b0;
        req        = '0;
        req_valid  = 1'b0;
        mem_ready  = 1'b0;
        mem_bvalid = 1'b0;
        load_table();
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            push_expected(stim_table[i]);
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;
        repeat (IDLE_CYCLES) @(posedge clk);
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            send_request(stim_table[i]);
        end
        while (exp_q.size() != 0 || resp_count != NUM_ENTRIES) begin
            @(posedge clk);
        end
        repeat (DRAIN_CYCLES) @(posedge clk);  // catch stray beats or acks.
        if (ack_count != NUM_ENTRIES) begin
            fail_run($sformatf("got %0d acknowledges for %0d requests",
                               ack_count, NUM_ENTRIES));
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* verilog.f */
logic/l2w_cfg_pkg.sv
logic/l2w_bus_pkg.sv
logic/wr_req_intake.sv
logic/write_arbiter.sv
logic/line_write_buffer.sv
logic/axi_wr_port.sv
logic/l2_write_path.sv
verif/tb_l2_write_path.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_l2_write_path
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TEST OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
